/* include/memgame_cfg.svh */
//**********************************************************
// Memory game configuration
// Sequence length, counter widths and the display and
// timeout windows, counted in game clock cycles
//**********************************************************

`ifndef MEMGAME_CFG_SVH
`define MEMGAME_CFG_SVH

// Rounds per game, also the ROM depth
`define MG_SEQ_LEN 16
// Round and address counter width
`define MG_ADDR_W 4

// Cycles an entry stays on the display
`define MG_SHOW_CYCLES 8
// Display timer width, holds MG_SHOW_CYCLES + 1
`define MG_SHOW_W 4

// Idle cycles allowed before a press
`define MG_TIMEOUT_CYCLES 50
// Timeout counter width, holds MG_TIMEOUT_CYCLES
`define MG_TIMEOUT_W 6

`endif

/* memoryGame.f */
+incdir+include
rtl/memGamePkg.sv
rtl/gameCtrlIf.sv
rtl/sequenceRom.sv
rtl/gameDatapath.sv
rtl/gameControl.sv
rtl/memoryGame.sv
sim/memoryGame_props.sv
sim/memoryGame_tb.sv

/* rtl/gameControl.sv */
//**********************************************************
// Memory game control FSM
// Shows the newest entry each round, collects the player's
// presses and records win, loss or timeout
//**********************************************************

`timescale 1ns/1ps

module gameControl (
    input  logic                clock,
    input  logic                arstN,
    input  logic                start,
    gameCtrlIf.ctrl             bus,
    output logic                busy,
    output logic                showValid,
    output memGamePkg::outcomeT outcome
);

    memGamePkg::gameStateT state;
    memGamePkg::gameStateT stateNext;
    memGamePkg::outcomeT   outcomeNext;

    // State and outcome registers
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            state   <= memGamePkg::idle;
            outcome <= memGamePkg::none;
        end else begin
            state   <= stateNext;
            outcome <= outcomeNext;
        end
    end

    // Next state, outcome and datapath strobes
    always_comb begin
        stateNext      = state;
        outcomeNext    = outcome;
        bus.clrRound   = 1'b0;
        bus.incRound   = 1'b0;
        bus.clrAddr    = 1'b0;
        bus.incAddr    = 1'b0;
        bus.loadPlay   = 1'b0;
        bus.startShow  = 1'b0;
        bus.armTimeout = 1'b0;
        case (state)
            // Waiting for start, last outcome held in done
            memGamePkg::idle,
            memGamePkg::done: begin
                if (start) begin
                    bus.clrRound = 1'b1;
                    outcomeNext  = memGamePkg::none;
                    stateNext    = memGamePkg::initRound;
                end
            end
            // Rewind the address, kick off the display timer
            memGamePkg::initRound: begin
                bus.clrAddr   = 1'b1;
                bus.startShow = 1'b1;
                stateNext     = memGamePkg::fetch;
            end
            // ROM read latency
            memGamePkg::fetch: begin
                stateNext = memGamePkg::show;
            end
            memGamePkg::show: begin
                if (bus.showDone) begin
                    bus.armTimeout = 1'b1;
                    stateNext      = memGamePkg::waitPress;
                end
            end
            // A press beats a timeout in the same cycle
            memGamePkg::waitPress: begin
                bus.loadPlay = 1'b1;
                if (bus.pressed) begin
                    stateNext = memGamePkg::check;
                end else if (bus.timedOut) begin
                    outcomeNext = memGamePkg::timeout;
                    stateNext   = memGamePkg::done;
                end
            end
            memGamePkg::check: begin
                if (!bus.match) begin
                    outcomeNext = memGamePkg::loss;
                    stateNext   = memGamePkg::done;
                end else if (!bus.addrEqRound) begin
                    stateNext = memGamePkg::nextEntry;
                end else if (bus.lastRound) begin
                    outcomeNext = memGamePkg::win;
                    stateNext   = memGamePkg::done;
                end else begin
                    stateNext = memGamePkg::nextRound;
                end
            end
            // More entries to repeat this round
            memGamePkg::nextEntry: begin
                bus.incAddr    = 1'b1;
                bus.armTimeout = 1'b1;
                stateNext      = memGamePkg::waitPress;
            end
            memGamePkg::nextRound: begin
                bus.incRound = 1'b1;
                stateNext    = memGamePkg::initRound;
            end
            default: begin
                stateNext = memGamePkg::idle;
            end
        endcase
    end

    // Status outputs decoded from the state
    assign busy      = (state != memGamePkg::idle) && (state != memGamePkg::done);
    assign showValid = (state == memGamePkg::show);

endmodule

/* rtl/gameCtrlIf.sv */
//**********************************************************
// Memory game control bundle
// Strobes from the FSM to the datapath and status flags
// from the datapath back to the FSM
//**********************************************************

`timescale 1ns/1ps

interface gameCtrlIf;

    // FSM strobes, single cycle pulses
    logic clrRound;
    logic incRound;
    logic clrAddr;
    logic incAddr;
    logic loadPlay;
    logic startShow;
    logic armTimeout;

    // Datapath flags, levels
    logic pressed;
    logic match;
    logic addrEqRound;
    logic lastRound;
    logic showDone;
    logic timedOut;

    // Display data for the top level
    memGamePkg::patternT showPattern;
    memGamePkg::addrT    roundNum;

    // FSM side
    modport ctrl (
        output clrRound, incRound, clrAddr, incAddr,
        output loadPlay, startShow, armTimeout,
        input  pressed, match, addrEqRound, lastRound, showDone, timedOut
    );

    // Datapath side
    modport data (
        input  clrRound, incRound, clrAddr, incAddr,
        input  loadPlay, startShow, armTimeout,
        output pressed, match, addrEqRound, lastRound, showDone, timedOut,
        output showPattern, roundNum
    );

endinterface

/* rtl/gameDatapath.sv */
//**********************************************************
// Memory game datapath
// Round and address counters, pattern ROM, play register,
// press edge detector, comparators and the display and
// timeout timers
//**********************************************************

`timescale 1ns/1ps
`include "memgame_cfg.svh"

module gameDatapath (
    input  logic                clock,
    input  logic                arstN,
    input  memGamePkg::patternT buttons,
    gameCtrlIf.data             bus
);

    // Counters
    memGamePkg::addrT         roundCnt;
    memGamePkg::addrT         addrCnt;
    // ROM side
    memGamePkg::addrT         romAddr;
    memGamePkg::patternT      romData;
    // Player input
    memGamePkg::patternT      playReg;
    logic                     anyHeld;
    logic                     heldQ;
    logic                     pressEdge;
    logic                     pressedQ;
    // Timers
    logic [`MG_SHOW_W-1:0]    showCnt;
    logic [`MG_TIMEOUT_W-1:0] toutCnt;

    // Clear wins over increment
    function automatic memGamePkg::addrT stepCount(
        input logic             clr,
        input logic             inc,
        input memGamePkg::addrT cur
    );
        memGamePkg::addrT nxt;
        nxt = cur;
        if (clr) begin
            nxt = '0;
        end else if (inc) begin
            nxt = cur + 1'b1;
        end
        return nxt;
    endfunction

    // Round and address counters
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            roundCnt <= '0;
            addrCnt  <= '0;
        end else begin
            roundCnt <= stepCount(bus.clrRound, bus.incRound, roundCnt);
            addrCnt  <= stepCount(bus.clrAddr, bus.incAddr, addrCnt);
        end
    end

    // Round index while displaying, address index while collecting
    assign romAddr = (showCnt != '0) ? roundCnt : addrCnt;

    sequenceRom rom (
        .clock (clock),
        .addr  (romAddr),
        .data  (romData)
    );

    // Press detection
    assign anyHeld   = |buttons;
    assign pressEdge = anyHeld && !heldQ;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            heldQ    <= 1'b0;
            pressedQ <= 1'b0;
        end else begin
            heldQ    <= anyHeld;
            // Only edges seen while the FSM is collecting count
            pressedQ <= bus.loadPlay && pressEdge;
        end
    end

    // Play register, takes the buttons on the press edge
    always_ff @(posedge clock) begin
        if (bus.loadPlay && pressEdge) begin
            playReg <= buttons;
        end
    end

    // Display timer
    // Loaded one above the show length so the fetch cycle is covered too
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            showCnt <= '0;
        end else if (bus.startShow) begin
            showCnt <= `MG_SHOW_W'(`MG_SHOW_CYCLES + 1);
        end else if (showCnt != '0) begin
            showCnt <= showCnt - 1'b1;
        end
    end

    // Timeout counter
    // Frozen while a button is held, sticks at the limit
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            toutCnt <= '0;
        end else if (bus.armTimeout) begin
            toutCnt <= '0;
        end else if (!anyHeld && !bus.timedOut) begin
            toutCnt <= toutCnt + 1'b1;
        end
    end

    // Flags back to the FSM
    assign bus.pressed     = pressedQ;
    assign bus.match       = (playReg == romData);
    assign bus.addrEqRound = (addrCnt == roundCnt);
    assign bus.lastRound   = (roundCnt == `MG_ADDR_W'(`MG_SEQ_LEN - 1));
    assign bus.showDone    = (showCnt == `MG_SHOW_W'(1));
    assign bus.timedOut    = (toutCnt == `MG_TIMEOUT_W'(`MG_TIMEOUT_CYCLES));

    // Display data
    assign bus.showPattern = romData;
    assign bus.roundNum    = roundCnt;

endmodule

/* rtl/memGamePkg.sv */
//**********************************************************
// Memory game types
// FSM states, final outcome and the shared sequence index
// and button pattern types
//**********************************************************

`include "memgame_cfg.svh"

package memGamePkg;

    // Index into the sequence, also the round number
    typedef logic [`MG_ADDR_W-1:0] addrT;

    // One-hot button pattern, one bit per button
    typedef logic [3:0] patternT;

    // Control FSM states
    typedef enum logic [3:0] {
        idle,
        initRound,
        fetch,
        show,
        waitPress,
        check,
        nextEntry,
        nextRound,
        done
    } gameStateT;

    // Result of the last game
    typedef enum logic [1:0] {
        none,
        win,
        loss,
        timeout
    } outcomeT;

endpackage

/* rtl/memoryGame.sv */
//**********************************************************
// Memory game top level
// Joins the control FSM and the datapath and brings the
// display and status out as plain ports
//**********************************************************

`timescale 1ns/1ps

module memoryGame (
    input  logic                clock,
    input  logic                arstN,
    input  logic                start,
    input  memGamePkg::patternT buttons,
    output logic                busy,
    output logic                showValid,
    output memGamePkg::patternT showPattern,
    output memGamePkg::addrT    round,
    output memGamePkg::outcomeT outcome
);

    // Strobes and flags between FSM and datapath
    gameCtrlIf bus ();

    gameControl control (
        .clock     (clock),
        .arstN     (arstN),
        .start     (start),
        .bus       (bus.ctrl),
        .busy      (busy),
        .showValid (showValid),
        .outcome   (outcome)
    );

    gameDatapath datapath (
        .clock   (clock),
        .arstN   (arstN),
        .buttons (buttons),
        .bus     (bus.data)
    );

    // Display entry and round number
    assign showPattern = bus.showPattern;
    assign round       = bus.roundNum;

endmodule

/* rtl/sequenceRom.sv */
//**********************************************************
// Pattern sequence ROM
// Sixteen fixed one-hot entries, synchronous read with
// one cycle of latency
//**********************************************************

`timescale 1ns/1ps

module sequenceRom (
    input  logic                clock,
    input  memGamePkg::addrT    addr,
    output memGamePkg::patternT data
);

    // Entry k lights bit (3k + k/4) mod 4
    always_ff @(posedge clock) begin
        case (addr)
            4'd0:  data <= 4'b0001;
            4'd1:  data <= 4'b1000;
            4'd2:  data <= 4'b0100;
            4'd3:  data <= 4'b0010;
            // Second group, shifted by one
            4'd4:  data <= 4'b0010;
            4'd5:  data <= 4'b0001;
            4'd6:  data <= 4'b1000;
            4'd7:  data <= 4'b0100;
            // Third group, shifted by two
            4'd8:  data <= 4'b0100;
            4'd9:  data <= 4'b0010;
            4'd10: data <= 4'b0001;
            4'd11: data <= 4'b1000;
            // Last group, shifted by three
            4'd12: data <= 4'b1000;
            4'd13: data <= 4'b0100;
            4'd14: data <= 4'b0010;
            4'd15: data <= 4'b0001;
            default: data <= 4'b0001;
        endcase
    end

endmodule

/* sim/memoryGame_props.sv */
//**********************************************************
// Memory game properties
// Reset, outcome and display timing rules on the top level
// status outputs
//**********************************************************

`timescale 1ns/1ps
`include "memgame_cfg.svh"

module memoryGame_props (
    input logic                clock,
    input logic                arstN,
    input logic                busy,
    input logic                showValid,
    input memGamePkg::outcomeT outcome
);

    // Failed assertions, read by the testbench summary
    int assertFails = 0;

    // Quiet outputs while in reset
    resetQuiet: assert property (@(posedge clock) !arstN |-> !showValid && !busy)
        else begin
            assertFails++;
            $error("busy or showValid high during reset");
        end

    // No result while a game runs
    noOutcomeWhileBusy: assert property (@(posedge clock) disable iff (!arstN)
        busy |-> outcome == memGamePkg::none)
        else begin
            assertFails++;
            $error("outcome set while busy");
        end

    // Display window length
    showLength: assert property (@(posedge clock) disable iff (!arstN)
        $rose(showValid) |-> showValid [*`MG_SHOW_CYCLES] ##1 !showValid)
        else begin
            assertFails++;
            $error("showValid window has the wrong length");
        end

    // Display only inside a game
    showOnlyBusy: assert property (@(posedge clock) disable iff (!arstN)
        $rose(showValid) |-> busy)
        else begin
            assertFails++;
            $error("showValid rose while busy was low");
        end

endmodule

bind memoryGame memoryGame_props props (
    .clock     (clock),
    .arstN     (arstN),
    .busy      (busy),
    .showValid (showValid),
    .outcome   (outcome)
);

/* sim/memoryGame_tb.sv */
//**********************************************************
// Memory game testbench
// Plays full, losing, idle, held press and restart games
// against a reference pattern model
//**********************************************************

`timescale 1ns/1ps
`include "memgame_cfg.svh"

module memoryGame_tb;

    logic                clock;
    logic                arstN;
    logic                start;
    memGamePkg::patternT buttons;
    logic                busy;
    logic                showValid;
    memGamePkg::patternT showPattern;
    memGamePkg::addrT    round;
    memGamePkg::outcomeT outcome;

    // Run bookkeeping
    int                  seed = 99;
    int                  checks = 0;
    int                  errors = 0;
    int                  testsRun = 0;
    int                  testErrStart = 0;
    string               curTest = "startup";
    memGamePkg::addrT    expRound = '0;
    int                  lossRound;
    int                  waited;
    memGamePkg::patternT wrongBtn;

    memoryGame DUT (
        .clock       (clock),
        .arstN       (arstN),
        .start       (start),
        .buttons     (buttons),
        .busy        (busy),
        .showValid   (showValid),
        .showPattern (showPattern),
        .round       (round),
        .outcome     (outcome)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Entry k lights bit (3k + k/4) mod 4
    function automatic memGamePkg::patternT refPattern(input int k);
        int pos;
        pos = (3 * k + k / 4) % 4;
        return memGamePkg::patternT'(1) << pos;
    endfunction

    task automatic checkPattern(input string what, input memGamePkg::patternT exp,
                                input memGamePkg::patternT act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s %s: expected %b, actual %b", curTest, what, exp, act);
        end
    endtask

    task automatic checkOutcome(input string what, input memGamePkg::outcomeT exp,
                                input memGamePkg::outcomeT act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s %s: expected %s, actual %s", curTest, what,
                     exp.name(), act.name());
        end
    endtask

    task automatic checkRound(input string what, input memGamePkg::addrT exp,
                              input memGamePkg::addrT act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s %s: expected %0d, actual %0d", curTest, what, exp, act);
        end
    endtask

    task automatic checkFlag(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s %s: expected %b, actual %b", curTest, what, exp, act);
        end
    endtask

    // Display pattern checked on every cycle of the window
    always @(posedge clock) begin
        #2;
        if (arstN && showValid) begin
            checkPattern("displayed entry", refPattern(expRound), showPattern);
        end
    end

    // Inputs change and outputs are read 1 ns after the edge
    task automatic nextCycle();
        @(posedge clock);
        #1;
    endtask

    task automatic abortRun(input string what);
        $display("Test %s stopped: %s", curTest, what);
        $display("*** FAILED ***");
        $finish;
    endtask

    task automatic waitShowStart();
        int n;
        n = 0;
        while (!showValid && n < 20) begin
            nextCycle();
            n++;
        end
        if (!showValid) begin
            abortRun("the display never started");
        end
    endtask

    task automatic waitShowEnd();
        int n;
        n = 0;
        while (showValid && n < `MG_SHOW_CYCLES + 4) begin
            nextCycle();
            n++;
        end
        if (showValid) begin
            abortRun("the display never ended");
        end
    endtask

    task automatic waitIdle(output int cycles);
        int n;
        n = 0;
        while (busy && n < `MG_TIMEOUT_CYCLES + 20) begin
            nextCycle();
            n++;
        end
        cycles = n;
        if (busy) begin
            abortRun("the game never finished");
        end
    endtask

    task automatic startGame();
        start = 1'b1;
        nextCycle();
        start = 1'b0;
    endtask

    // Release long enough for check and next entry to pass
    task automatic pressButton(input memGamePkg::patternT p, input int holdCycles);
        buttons = p;
        repeat (holdCycles) nextCycle();
        buttons = '0;
        repeat (3) nextCycle();
    endtask

    task automatic showRound(input int rnd);
        expRound = memGamePkg::addrT'(rnd);
        waitShowStart();
        checkRound("round number", memGamePkg::addrT'(rnd), round);
        waitShowEnd();
    endtask

    task automatic repeatEntries(input int first, input int last);
        for (int e = first; e <= last; e++) begin
            pressButton(refPattern(e), 2);
        end
    endtask

    task automatic playRounds(input int first, input int last);
        for (int rnd = first; rnd <= last; rnd++) begin
            showRound(rnd);
            repeatEntries(0, rnd);
        end
    endtask

    task automatic beginTest(input string name);
        curTest = name;
        testErrStart = errors;
        testsRun++;
    endtask

    task automatic endTest();
        if (errors == testErrStart) begin
            $display("Test %s: ok", curTest);
        end else begin
            $display("Test %s: %0d errors", curTest, errors - testErrStart);
        end
    endtask

    initial begin
        arstN   = 1'b0;
        start   = 1'b0;
        buttons = '0;
        repeat (2) @(posedge clock);
        #1;
        arstN = 1'b1;

        beginTest("reset");
        checkFlag("busy", 1'b0, busy);
        checkFlag("showValid", 1'b0, showValid);
        checkOutcome("outcome", memGamePkg::none, outcome);
        endTest();

        beginTest("full game");
        startGame();
        playRounds(0, `MG_SEQ_LEN - 1);
        waitIdle(waited);
        checkOutcome("outcome", memGamePkg::win, outcome);
        checkRound("final round", memGamePkg::addrT'(`MG_SEQ_LEN - 1), round);
        endTest();

        // Random losing round and a wrong button for its newest entry
        beginTest("wrong button");
        lossRound = {$random(seed)} % `MG_SEQ_LEN;
        wrongBtn  = memGamePkg::patternT'(1) << ({$random(seed)} % 4);
        if (wrongBtn == refPattern(lossRound)) begin
            wrongBtn = {wrongBtn[2:0], wrongBtn[3]};
        end
        startGame();
        playRounds(0, lossRound - 1);
        showRound(lossRound);
        repeatEntries(0, lossRound - 1);
        pressButton(wrongBtn, 2);
        waitIdle(waited);
        checkOutcome("outcome", memGamePkg::loss, outcome);
        checkRound("losing round", memGamePkg::addrT'(lossRound), round);
        endTest();

        beginTest("timeout");
        startGame();
        showRound(0);
        waitIdle(waited);
        checkOutcome("outcome", memGamePkg::timeout, outcome);
        checkRound("round at timeout", '0, round);
        checks++;
        if (waited < `MG_TIMEOUT_CYCLES) begin
            errors++;
            $display("Test %s: the game ended before the timeout window ran out", curTest);
        end
        endTest();

        // First entry of round 1 held well past one press
        beginTest("held press");
        startGame();
        playRounds(0, 0);
        showRound(1);
        buttons = refPattern(0);
        repeat (12) nextCycle();
        checkFlag("busy during hold", 1'b1, busy);
        checkRound("round during hold", 1, round);
        checkOutcome("outcome during hold", memGamePkg::none, outcome);
        repeat (8) nextCycle();
        buttons = '0;
        repeat (3) nextCycle();
        pressButton(refPattern(1), 2);
        playRounds(2, `MG_SEQ_LEN - 1);
        waitIdle(waited);
        checkOutcome("outcome", memGamePkg::win, outcome);
        endTest();

        beginTest("restart");
        startGame();
        checkOutcome("outcome after start", memGamePkg::none, outcome);
        checkFlag("busy after start", 1'b1, busy);
        playRounds(0, 0);
        showRound(1);
        waitIdle(waited);
        checkOutcome("outcome", memGamePkg::timeout, outcome);
        checkRound("round at timeout", 1, round);
        endTest();

        $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 testsRun, checks, errors, DUT.props.assertFails);
        if (errors == 0 && DUT.props.assertFails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
